//--- source/pa_pkg.sv
package pa_pkg;

	// default data width of the arithmetic unit
	localparam int pa_width = 16;

	// instruction operations, unlisted codes act as no-op
	typedef enum logic [3:0] {
		op_lw  = 4'h0,
		op_lwr = 4'h1,
		op_aw  = 4'h2,
		op_sw  = 4'h3,
		op_nr  = 4'h4,
		op_or  = 4'h5,
		op_er  = 4'h6,
		op_cw  = 4'h7,
		op_slz = 4'h8,
		op_shc = 4'h9
	} pa_opcode_t;

	// operand bus sources
	typedef enum logic [1:0] {
		src_data = 2'd0,
		src_ar   = 2'd1,
		src_imm  = 2'd2
	} pa_src_t;

	// alu functions
	typedef enum logic [2:0] {
		alu_pass = 3'd0,
		alu_add  = 3'd1,
		alu_sub  = 3'd2,
		alu_and  = 3'd3,
		alu_or   = 3'd4,
		alu_xor  = 3'd5
	} pa_aluop_t;

	// one instruction word, two formats
	typedef union packed {
		struct packed {
			pa_opcode_t opcode;
			pa_src_t    src;
			logic [1:0] reserved;
			logic [7:0] imm;
		} arith;
		struct packed {
			pa_opcode_t opcode;
			logic [6:0] reserved;
			logic       fill;
			logic [3:0] count;
		} shift;
	} pa_instr_t;

endpackage

//--- source/pa_ctrl_if.sv
`timescale 1ns/10ps

interface pa_ctrl_if;
	import pa_pkg::*;

	// operand bus and alu steering
	pa_src_t   src;
	pa_aluop_t aluop;

	// register write strobes
	logic load_ac;
	logic load_ar;

	// shift register control
	logic at_load;
	logic at_step;
	logic at_to_ac;

	modport ctrl (
		output src, aluop, load_ac, load_ar, at_load, at_step, at_to_ac
	);

	modport dp (
		input src, aluop, load_ac, load_ar, at_load, at_step, at_to_ac
	);

endinterface

//--- source/pa_shift_timer.sv
`timescale 1ns/10ps

module pa_shift_timer (
	input  logic       clk,
	input  logic       rst,
	input  logic       load,
	input  logic [3:0] count,
	output logic       expired
);

	logic [3:0] cnt;

	// counts down to zero and rests there
	always_ff @(posedge clk) begin
		if (rst)
			cnt <= 4'd0;
		else if (load)
			cnt <= count;
		else if (cnt != 4'd0)
			cnt <= cnt - 4'd1;
	end

	assign expired = (cnt == 4'd0);

	// a new count only starts once the last one has run out
	a_load_when_expired: assert property (@(posedge clk) disable iff (rst)
		load |-> expired);

endmodule

//--- source/pa_alu.sv
`timescale 1ns/10ps

module pa_alu #(
	parameter int WIDTH = pa_pkg::pa_width
) (
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  pa_pkg::pa_aluop_t aluop,
	output logic [WIDTH-1:0] f,
	output logic             carry,
	output logic             zero
);
	import pa_pkg::*;

	logic [WIDTH-1:0] b_in;
	logic             cin;
	logic [WIDTH:0]   sum;

	// subtract is a + ~b + 1 on the same adder
	assign cin = (aluop == alu_sub);
	assign b_in = cin ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, b_in} + {{WIDTH{1'b0}}, cin};

	always_comb begin
		carry = 1'b0;
		case (aluop)
			alu_pass: f = b;
			alu_add, alu_sub: begin
				f = sum[WIDTH-1:0];
				carry = sum[WIDTH];
			end
			alu_and: f = a & b;
			alu_or: f = a | b;
			alu_xor: f = a ^ b;
			default: f = b;
		endcase
	end

	assign zero = (f == '0);

endmodule

//--- source/pa_sequencer.sv
`timescale 1ns/10ps

module pa_sequencer (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  pa_pkg::pa_instr_t instr,
	input  logic              expired,
	output logic              timer_load,
	output logic [3:0]        timer_count,
	output logic              busy,
	output logic              done,
	pa_ctrl_if.ctrl           ctl
);
	import pa_pkg::*;

	localparam logic [2:0] st_idle      = 3'd0;
	localparam logic [2:0] st_decode    = 3'd1;
	localparam logic [2:0] st_execute   = 3'd2;
	localparam logic [2:0] st_shift     = 3'd3;
	localparam logic [2:0] st_writeback = 3'd4;

	logic [2:0] state;
	logic [2:0] next_state;
	pa_instr_t  ir;
	logic       accept;
	logic       is_shift;
	logic       writes_ac;
	logic       writes_ar;

	assign busy = (state != st_idle);
	assign done = (state == st_writeback);
	assign accept = start && !busy;

	always_ff @(posedge clk) begin
		if (accept)
			ir <= instr;
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_idle;
		else
			state <= next_state;
	end

	// opcode decode through the arith view
	always_comb begin
		is_shift = 1'b0;
		writes_ac = 1'b0;
		writes_ar = 1'b0;
		ctl.aluop = alu_pass;
		case (ir.arith.opcode)
			op_lw: writes_ac = 1'b1;
			op_lwr: writes_ar = 1'b1;
			op_aw: begin
				writes_ac = 1'b1;
				ctl.aluop = alu_add;
			end
			// compare goes through load_ac, AC write is held off in the datapath
			op_sw, op_cw: begin
				writes_ac = 1'b1;
				ctl.aluop = alu_sub;
			end
			op_nr: begin
				writes_ac = 1'b1;
				ctl.aluop = alu_and;
			end
			op_or: begin
				writes_ac = 1'b1;
				ctl.aluop = alu_or;
			end
			op_er: begin
				writes_ac = 1'b1;
				ctl.aluop = alu_xor;
			end
			op_slz, op_shc: is_shift = 1'b1;
			default: is_shift = 1'b0;
		endcase
	end

	assign ctl.src = ir.arith.src;
	assign timer_count = ir.shift.count;

	always_comb begin
		next_state = state;
		timer_load = 1'b0;
		ctl.load_ac = 1'b0;
		ctl.load_ar = 1'b0;
		ctl.at_load = 1'b0;
		ctl.at_step = 1'b0;
		ctl.at_to_ac = 1'b0;
		case (state)
			st_idle: begin
				if (start)
					next_state = st_decode;
			end
			st_decode: begin
				if (is_shift) begin
					timer_load = 1'b1;
					ctl.at_load = 1'b1;
					next_state = st_shift;
				end else begin
					next_state = st_execute;
				end
			end
			st_execute: begin
				ctl.load_ac = writes_ac;
				ctl.load_ar = writes_ar;
				next_state = st_writeback;
			end
			// one AT step per cycle, AT goes back to AC on the last one
			st_shift: begin
				if (expired) begin
					ctl.at_to_ac = 1'b1;
					next_state = st_writeback;
				end else begin
					ctl.at_step = 1'b1;
				end
			end
			st_writeback: next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

	// timer leaves zero once a nonzero count is loaded
	a_timer_took_count: assert property (@(posedge clk) disable iff (rst)
		(timer_load && timer_count != 4'd0) |=> !expired);

endmodule

//--- source/pa_datapath.sv
`timescale 1ns/10ps

module pa_datapath #(
	parameter int WIDTH = pa_pkg::pa_width
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              start_accept,
	input  pa_pkg::pa_instr_t instr,
	input  logic [WIDTH-1:0]  data,
	pa_ctrl_if.dp             ctl,
	output logic [WIDTH-1:0]  ac,
	output logic [WIDTH-1:0]  ar,
	output logic              zero_flag,
	output logic              carry_flag
);
	import pa_pkg::*;

	pa_instr_t        ir;
	logic [WIDTH-1:0] dr;
	logic [WIDTH-1:0] at;
	logic [WIDTH-1:0] bus;
	logic [WIDTH-1:0] f;
	logic             alu_carry;
	logic             alu_zero;
	logic             is_compare;

	always_ff @(posedge clk) begin
		if (start_accept) begin
			ir <= instr;
			dr <= data;
		end
	end

	// operand bus, immediate is sign-extended
	always_comb begin
		case (ctl.src)
			src_ar: bus = ar;
			src_imm: bus = {{(WIDTH-8){ir.arith.imm[7]}}, ir.arith.imm};
			default: bus = dr;
		endcase
	end

	pa_alu #(
		.WIDTH(WIDTH)
	) alu_i (
		.a(ac),
		.b(bus),
		.aluop(ctl.aluop),
		.f(f),
		.carry(alu_carry),
		.zero(alu_zero)
	);

	assign is_compare = (ir.arith.opcode == op_cw);

	// AC and flags; a compare only touches the flags
	always_ff @(posedge clk) begin
		if (rst) begin
			ac <= '0;
			zero_flag <= 1'b0;
			carry_flag <= 1'b0;
		end else if (ctl.load_ac) begin
			if (!is_compare)
				ac <= f;
			zero_flag <= alu_zero;
			carry_flag <= alu_carry;
		end else if (ctl.at_to_ac) begin
			ac <= at;
			zero_flag <= (at == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			ar <= '0;
		else if (ctl.load_ar)
			ar <= bus;
	end

	// shift left takes the fill bit in, rotate right wraps bit 0 to the top
	always_ff @(posedge clk) begin
		if (rst) begin
			at <= '0;
		end else if (ctl.at_load) begin
			at <= ac;
		end else if (ctl.at_step) begin
			if (ir.shift.opcode == op_slz)
				at <= {at[WIDTH-2:0], ir.shift.fill};
			else
				at <= {at[0], at[WIDTH-1:1]};
		end
	end

	// load_ac and at_to_ac never come together
	a_one_ac_writer: assert property (@(posedge clk) disable iff (rst)
		!(ctl.load_ac && ctl.at_to_ac));

endmodule

//--- source/pa_top.sv
`timescale 1ns/10ps

module pa_top #(
	parameter int WIDTH = pa_pkg::pa_width
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  logic [15:0]      instr,
	input  logic [WIDTH-1:0] data,
	output logic [WIDTH-1:0] ac,
	output logic [WIDTH-1:0] ar,
	output logic             zero_flag,
	output logic             carry_flag,
	output logic             busy,
	output logic             done
);

	logic       timer_load;
	logic [3:0] timer_count;
	logic       expired;
	logic       start_accept;

	pa_ctrl_if ctl_if ();

	// a start while busy is dropped
	assign start_accept = start && !busy;

	pa_sequencer sequencer_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.instr(instr),
		.expired(expired),
		.timer_load(timer_load),
		.timer_count(timer_count),
		.busy(busy),
		.done(done),
		.ctl(ctl_if.ctrl)
	);

	pa_shift_timer timer_i (
		.clk(clk),
		.rst(rst),
		.load(timer_load),
		.count(timer_count),
		.expired(expired)
	);

	pa_datapath #(
		.WIDTH(WIDTH)
	) datapath_i (
		.clk(clk),
		.rst(rst),
		.start_accept(start_accept),
		.instr(instr),
		.data(data),
		.ctl(ctl_if.dp),
		.ac(ac),
		.ar(ar),
		.zero_flag(zero_flag),
		.carry_flag(carry_flag)
	);

endmodule

//--- tests/pa_tb.sv
`timescale 1ns/10ps

module pa_tb;
	import pa_pkg::*;

	localparam int n_rows = 23;
	localparam int done_timeout = 40;

	logic        clk;
	logic        rst;
	logic        start;
	logic [15:0] instr;
	logic [15:0] data;
	logic [15:0] ac;
	logic [15:0] ar;
	logic        zero_flag;
	logic        carry_flag;
	logic        busy;
	logic        done;

	// one row per instruction, expected columns filled by the model
	logic [15:0] t_instr [n_rows];
	logic [15:0] t_data [n_rows];
	logic        t_poke [n_rows];
	logic [15:0] t_ac [n_rows];
	logic [15:0] t_ar [n_rows];
	logic        t_zero [n_rows];
	logic        t_carry [n_rows];
	int          t_lat [n_rows];

	logic [15:0] m_ac;
	logic [15:0] m_ar;
	logic        m_zero;
	logic        m_carry;
	logic [31:0] lfsr;
	int          passed;
	int          failed;

	pa_top #(
		.WIDTH(16)
	) pa_top_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.instr(instr),
		.data(data),
		.ac(ac),
		.ar(ar),
		.zero_flag(zero_flag),
		.carry_flag(carry_flag),
		.busy(busy),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// one lfsr step per bit
	task automatic next_rand_word(output logic [15:0] w);
		int k;
		for (k = 0; k < 16; k++) begin
			w[k] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [15:0] arith_word(input logic [3:0] op, input logic [1:0] src,
		input logic [7:0] imm);
		return {op, src, 2'b00, imm};
	endfunction

	function automatic logic [15:0] shift_word(input logic [3:0] op, input logic fill,
		input logic [3:0] count);
		return {op, 7'd0, fill, count};
	endfunction

	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		$display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
	endtask

	// reference model, applies row i to the model registers
	task automatic model_apply(input int i);
		logic [3:0]  op;
		logic [1:0]  src;
		logic [15:0] b;
		logic [16:0] s;
		logic [15:0] v;
		op = t_instr[i][15:12];
		src = t_instr[i][11:10];
		if (src == src_ar)
			b = m_ar;
		else if (src == src_imm)
			b = {{8{t_instr[i][7]}}, t_instr[i][7:0]};
		else
			b = t_data[i];
		v = m_ac;
		t_lat[i] = 3;
		case (op)
			op_lw: begin
				m_ac = b;
				m_carry = 1'b0;
				m_zero = (b == 16'h0);
			end
			op_lwr: m_ar = b;
			op_aw, op_sw, op_cw: begin
				if (op == op_aw)
					s = {1'b0, m_ac} + {1'b0, b};
				else
					s = {1'b0, m_ac} + {1'b0, ~b} + 17'd1;
				if (op != op_cw)
					m_ac = s[15:0];
				m_carry = s[16];
				m_zero = (s[15:0] == 16'h0);
			end
			op_nr, op_or, op_er: begin
				if (op == op_nr)
					m_ac = m_ac & b;
				else if (op == op_or)
					m_ac = m_ac | b;
				else
					m_ac = m_ac ^ b;
				m_carry = 1'b0;
				m_zero = (m_ac == 16'h0);
			end
			op_slz, op_shc: begin
				repeat (t_instr[i][3:0]) begin
					if (op == op_slz)
						v = {v[14:0], t_instr[i][4]};
					else
						v = {v[0], v[15:1]};
				end
				m_ac = v;
				m_zero = (v == 16'h0);
				t_lat[i] = 3 + t_instr[i][3:0];
			end
			default: ;
		endcase
		t_ac[i] = m_ac;
		t_ar[i] = m_ar;
		t_zero[i] = m_zero;
		t_carry[i] = m_carry;
	endtask

	task automatic build_table();
		int i;
		t_instr[0] = arith_word(op_lwr, src_data, 8'h00);
		t_instr[1] = arith_word(op_lw, src_ar, 8'h00);
		// x minus x
		t_instr[2] = arith_word(op_sw, src_ar, 8'h00);
		t_instr[3] = arith_word(op_lw, src_data, 8'h00);
		t_instr[4] = arith_word(op_aw, src_data, 8'h00);
		t_instr[5] = arith_word(op_sw, src_data, 8'h00);
		t_instr[6] = arith_word(op_lw, src_imm, 8'hff);
		// 0xffff plus 1
		t_instr[7] = arith_word(op_aw, src_imm, 8'h01);
		t_instr[8] = arith_word(op_lwr, src_imm, 8'h9c);
		// carry out of the next add, so the logic ops must clear it
		t_instr[9] = arith_word(op_lw, src_imm, 8'h75);
		t_instr[10] = arith_word(op_aw, src_ar, 8'h00);
		t_instr[11] = arith_word(op_nr, src_data, 8'h00);
		t_instr[12] = arith_word(op_or, src_data, 8'h00);
		t_instr[13] = arith_word(op_er, src_data, 8'h00);
		t_instr[14] = arith_word(op_cw, src_data, 8'h00);
		// compare with zero sets carry ahead of the shifts
		t_instr[15] = arith_word(op_cw, src_imm, 8'h00);
		t_instr[16] = shift_word(op_slz, 1'b0, 4'd1);
		t_instr[17] = shift_word(op_slz, 1'b1, 4'd7);
		t_instr[18] = shift_word(op_shc, 1'b0, 4'd15);
		t_instr[19] = shift_word(op_shc, 1'b0, 4'd0);
		t_instr[20] = shift_word(op_slz, 1'b1, 4'd15);
		t_instr[21] = arith_word(op_er, src_ar, 8'h00);
		// unused opcode, nothing changes
		t_instr[22] = arith_word(4'hf, src_data, 8'h00);
		for (i = 0; i < n_rows; i++) begin
			next_rand_word(t_data[i]);
			t_poke[i] = 1'b0;
		end
		t_poke[11] = 1'b1;
		t_poke[17] = 1'b1;
		m_ac = 16'h0;
		m_ar = 16'h0;
		m_zero = 1'b0;
		m_carry = 1'b0;
		for (i = 0; i < n_rows; i++)
			model_apply(i);
	endtask

	task automatic check_reset();
		int errs;
		errs = 0;
		if (ac !== 16'h0) begin
			report_mismatch("ac", ac, 16'h0);
			errs++;
		end
		if (ar !== 16'h0) begin
			report_mismatch("ar", ar, 16'h0);
			errs++;
		end
		if (zero_flag !== 1'b0) begin
			report_mismatch("zero_flag", zero_flag, 16'h0);
			errs++;
		end
		if (carry_flag !== 1'b0) begin
			report_mismatch("carry_flag", carry_flag, 16'h0);
			errs++;
		end
		if (busy !== 1'b0) begin
			report_mismatch("busy", busy, 16'h0);
			errs++;
		end
		if (done !== 1'b0) begin
			report_mismatch("done", done, 16'h0);
			errs++;
		end
		if (errs == 0) begin
			passed++;
			$display("test reset ok");
		end else begin
			failed++;
			$display("test reset failed");
		end
	endtask

	task automatic run_row(input int i);
		int   errs;
		int   lat;
		int   n;
		logic seen;
		errs = 0;
		n = 0;
		while (busy && n < done_timeout) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			$display("test %0d: unit stayed busy before start", i);
			errs++;
		end
		instr = t_instr[i];
		data = t_data[i];
		start = 1'b1;
		lat = 0;
		seen = 1'b0;
		while (!seen && lat < done_timeout) begin
			@(negedge clk);
			lat++;
			start = 1'b0;
			// second start while busy, must be dropped
			if (lat == 1 && t_poke[i]) begin
				start = 1'b1;
				instr = arith_word(op_lw, src_imm, 8'h77);
				data = ~t_data[i];
			end
			if (!busy) begin
				$display("test %0d: busy low before done", i);
				errs++;
			end
			if (done)
				seen = 1'b1;
		end
		if (!seen) begin
			$display("test %0d: done did not arrive within %0d cycles", i, done_timeout);
			errs++;
		end
		if (lat != t_lat[i]) begin
			report_mismatch("latency", lat, t_lat[i]);
			errs++;
		end
		if (ac !== t_ac[i]) begin
			report_mismatch("ac", ac, t_ac[i]);
			errs++;
		end
		if (ar !== t_ar[i]) begin
			report_mismatch("ar", ar, t_ar[i]);
			errs++;
		end
		if (zero_flag !== t_zero[i]) begin
			report_mismatch("zero_flag", zero_flag, t_zero[i]);
			errs++;
		end
		if (carry_flag !== t_carry[i]) begin
			report_mismatch("carry_flag", carry_flag, t_carry[i]);
			errs++;
		end
		if (errs == 0) begin
			passed++;
			$display("test %0d instr %h data %h ok", i, t_instr[i], t_data[i]);
		end else begin
			failed++;
			$display("test %0d instr %h data %h failed", i, t_instr[i], t_data[i]);
		end
	endtask

	initial begin
		int i;
		rst = 1'b1;
		start = 1'b0;
		instr = 16'h0;
		data = 16'h0;
		passed = 0;
		failed = 0;
		lfsr = 32'hcb5c_1ec3;
		build_table();
		repeat (8) @(negedge clk);
		rst = 1'b0;
		check_reset();
		for (i = 0; i < n_rows; i++)
			run_row(i);
		$display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
		if (failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- sources.f
source/pa_pkg.sv
source/pa_ctrl_if.sv
source/pa_shift_timer.sv
source/pa_alu.sv
source/pa_sequencer.sv
source/pa_datapath.sv
source/pa_top.sv
tests/pa_tb.sv

//--- Bender.yml
package:
  name: pa_unit

sources:
  - source/pa_pkg.sv
  - source/pa_ctrl_if.sv
  - source/pa_shift_timer.sv
  - source/pa_alu.sv
  - source/pa_sequencer.sv
  - source/pa_datapath.sv
  - source/pa_top.sv
  - target: simulation
    files:
      - tests/pa_tb.sv
